// File: Makefile
VERILATOR ?= verilator
TOP       ?= irig_tb
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FLIST)))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/irig_tb.sv
// irig-b decoder testbench
// generates irig-b frames on the code input and checks the ascii lines
// that come out of the character stream
`timescale 1ns/1ps
`default_nettype none

module irig_tb;
	import irig_pkg::*;

	localparam int NUM_FRAMES     = 12;
	localparam int TIMEOUT_CYCLES = NUM_FRAMES * 100 * SYM_CYCLES * 3 / 2;
	localparam int NO_INDEX       = -1;

	// one time record, bcd, in line order year first
	typedef struct packed {
		logic [YEAR_W-1:0] year;
		logic [DAY_W-1:0]  day;
		logic [HOUR_W-1:0] hrs;
		logic [MIN_W-1:0]  mins;
		logic [SEC_W-1:0]  sec;
	} time_rec_t;

	logic        clk;
	logic        rst_n;
	logic        bcode_in;
	logic [7:0]  char_data;
	logic        char_valid;
	logic        char_ready   = 1'b1;
	logic        random_ready;
	logic [31:0] rng_state    = 32'hea53;
	int          cycle_count  = 0;
	int          char_errors  = 0;
	int          count_errors = 0;
	logic [7:0]  got_q[$];
	logic [7:0]  exp_q[$];

	irig_decoder_top irig_decoder_top_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.bcode_in   (bcode_in),
		.char_data  (char_data),
		.char_valid (char_valid),
		.char_ready (char_ready)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// sink side, always ready unless back-pressure is on
	always @(posedge clk) begin
		if (random_ready) begin
			rng_state  <= xorshift32(rng_state);
			char_ready <= rng_state[3];
		end else begin
			char_ready <= 1'b1;
		end
	end

	always @(posedge clk) begin
		if (rst_n && char_valid && char_ready)
			got_q.push_back(char_data);    // accepted character
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// waveform generation
	// ------------------------------------------------------------------------
	task automatic send_symbol(input int high);
		int i;
		for (i = 0; i < SYM_CYCLES; i++) begin
			@(posedge clk);
			bcode_in <= (i < high);
		end
	endtask

	function automatic int sym_width(input sym_t s);
		case (s)
			SYM_ZERO: return W_ZERO;
			SYM_ONE:  return W_ONE;
			SYM_MARK: return W_MARK;
			default:  return 0;
		endcase
	endfunction

	// standard irig-b bit positions, lsb first within each digit
	function automatic logic field_bit(input int i, input time_rec_t r);
		case (i) inside
			[1:4]:   return r.sec[i - 1];
			[6:8]:   return r.sec[i - 2];     // seconds tens
			[10:13]: return r.mins[i - 10];
			[15:17]: return r.mins[i - 11];
			[20:23]: return r.hrs[i - 20];
			[25:26]: return r.hrs[i - 21];
			[30:33]: return r.day[i - 30];
			[35:38]: return r.day[i - 31];
			[40:41]: return r.day[i - 32];    // day hundreds
			[50:53]: return r.year[i - 50];
			[55:58]: return r.year[i - 51];
			default: return 1'b0;             // control bits and unused
		endcase
	endfunction

	// 100 symbols from Pr to P0, with one symbol swapped or widened
	// tol moves odd symbols up and even symbols down
	task automatic send_frame_mod(input time_rec_t r, input int swap_idx, input sym_t swap_sym,
		input int wide_idx, input int wide_extra, input int tol);
		sym_t s;
		int   w;
		int   i;
		for (i = 0; i < 100; i++) begin
			if (i == 0 || i % 10 == 9)
				s = SYM_MARK;
			else if (field_bit(i, r))
				s = SYM_ONE;
			else
				s = SYM_ZERO;
			if (i == swap_idx)
				s = swap_sym;
			w = sym_width(s) + ((i % 2 == 1) ? tol : -tol);
			if (i == wide_idx)
				w = w + wide_extra;
			send_symbol(w);
		end
	endtask

	task automatic send_frame(input time_rec_t r);
		send_frame_mod(r, NO_INDEX, SYM_ZERO, NO_INDEX, 0, 0);
	endtask

	// ------------------------------------------------------------------------
	// expected line and checks
	// ------------------------------------------------------------------------
	function automatic logic [7:0] to_ascii(input logic [3:0] nib);
		if (nib > 4'd9)
			return 8'h3F;
		return 8'h30 + {4'h0, nib};
	endfunction

	task automatic push_text(input string s);
		int k;
		for (k = 0; k < s.len(); k++)
			exp_q.push_back(s[k]);
	endtask

	task automatic expect_line(input time_rec_t r);
		push_text("TIME:20");
		exp_q.push_back(to_ascii(r.year[7:4]));
		exp_q.push_back(to_ascii(r.year[3:0]));
		push_text("-");
		exp_q.push_back(to_ascii({2'b00, r.day[9:8]}));
		exp_q.push_back(to_ascii(r.day[7:4]));
		exp_q.push_back(to_ascii(r.day[3:0]));
		push_text("day-");
		exp_q.push_back(to_ascii({2'b00, r.hrs[5:4]}));
		exp_q.push_back(to_ascii(r.hrs[3:0]));
		push_text(":");
		exp_q.push_back(to_ascii({1'b0, r.mins[6:4]}));
		exp_q.push_back(to_ascii(r.mins[3:0]));
		push_text(":");
		exp_q.push_back(to_ascii({1'b0, r.sec[6:4]}));
		exp_q.push_back(to_ascii(r.sec[3:0]));
	endtask

	task automatic compare_char(input logic [7:0] got, input logic [7:0] exp, input int pos);
		if (got !== exp) begin
			char_errors++;
			$display("Error at time %0t: character %0d is 8'h%02h, expected 8'h%02h",
				$time, pos, got, exp);
		end
	endtask

	task automatic compare_count(input int got, input int exp, input string what);
		if (got != exp) begin
			count_errors++;
			$display("Error at time %0t: %s gave %0d characters, expected %0d",
				$time, what, got, exp);
		end
	endtask

	// waits for the expected characters, bounded, then compares
	task automatic check_output(input string what);
		int waited;
		int k;
		waited = 0;
		while (got_q.size() < exp_q.size() && waited < 4 * SYM_CYCLES) begin
			@(posedge clk);
			waited++;
		end
		compare_count(got_q.size(), exp_q.size(), what);
		for (k = 0; k < got_q.size() && k < exp_q.size(); k++)
			compare_char(got_q[k], exp_q[k], k);
		got_q.delete();
		exp_q.delete();
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------
	task automatic test_single_frame();
		time_rec_t r;
		r = {8'h24, 10'h365, 6'h23, 7'h59, 7'h58};    // year, day, hours, minutes, seconds
		repeat (20 * SYM_CYCLES) @(posedge clk);     // quiet line
		check_output("idle input");
		send_symbol(W_MARK);                          // P0 ahead of the first Pr
		expect_line(r);
		send_frame(r);
		check_output("single frame");
	endtask

	task automatic test_backpressure();
		time_rec_t r [3];
		int k;
		r[0] = {8'h25, 10'h001, 6'h00, 7'h00, 7'h00};
		r[1] = {8'h99, 10'h128, 6'h12, 7'h34, 7'h56};
		r[2] = {8'h30, 10'h240, 6'h09, 7'h05, 7'h07};
		random_ready <= 1'b1;
		for (k = 0; k < 3; k++) begin
			expect_line(r[k]);
			send_frame(r[k]);
		end
		random_ready <= 1'b0;
		check_output("three frames under back-pressure");
	endtask

	task automatic test_hunt();
		time_rec_t r;
		int k;
		r = {8'h31, 10'h072, 6'h18, 7'h45, 7'h12};
		send_symbol(W_ZERO);    // breaks the pair left by the last P0
		send_symbol(W_MARK);    // lone marker
		for (k = 1; k <= FRAME_LAST; k++) begin
			if (k % 10 == 9)
				send_symbol(W_MARK);    // position markers without Pr
			else
				send_symbol((k % 3 == 0) ? W_ONE : W_ZERO);
		end
		send_symbol(W_ZERO);
		check_output("data without marker pair");
		send_symbol(W_MARK);
		expect_line(r);
		send_frame(r);
		check_output("frame after marker pair");
	endtask

	task automatic test_marker_error();
		time_rec_t r;
		r = {8'h27, 10'h300, 6'h06, 7'h30, 7'h15};
		send_frame_mod(r, 29, SYM_ZERO, NO_INDEX, 0, 0);    // P3 missing
		check_output("frame with bad P3");
		r.sec = 7'h16;
		expect_line(r);
		send_frame(r);
		check_output("frame after bad P3");
	endtask

	task automatic test_width_tolerance();
		time_rec_t r;
		r = {8'h42, 10'h199, 6'h21, 7'h08, 7'h33};
		expect_line(r);
		send_frame_mod(r, NO_INDEX, SYM_ZERO, NO_INDEX, 0, W_TOL);
		check_output("widths at tolerance edge");
		send_frame_mod(r, NO_INDEX, SYM_ZERO, 12, W_TOL + 2, 0);
		check_output("width beyond tolerance");
	endtask

	task automatic test_bad_nibble();
		time_rec_t r;
		r = {8'h26, 10'h200, 6'h14, 7'h07, 7'h5C};    // seconds units of 4'hC
		expect_line(r);
		send_frame(r);
		check_output("seconds nibble above 9");
	endtask

	initial begin
		clk          = 1'b0;
		rst_n        <= 1'b0;
		bcode_in     <= 1'b0;
		random_ready <= 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		test_single_frame();
		test_backpressure();
		test_hunt();
		test_marker_error();
		test_width_tolerance();
		test_bad_nibble();

		$display("errors: %0d character, %0d count", char_errors, count_errors);
		if (char_errors == 0 && count_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/irig_ascii_formatter.sv
// time record to ascii line formatter
// latches one record and sends "TIME:20YY-DDDday-HH:MM:SS" a character
// at a time on a valid/ready stream
`timescale 1ns/1ps
`default_nettype none

module irig_ascii_formatter (
	input  logic       clk,
	input  logic       rst_n,
	irig_time_if.snk   time_if,
	output logic [7:0] char_data,
	output logic       char_valid,
	input  logic       char_ready
);
	import irig_pkg::*;

	logic              busy;
	logic [4:0]        char_idx;
	logic [SEC_W-1:0]  sec_q;
	logic [MIN_W-1:0]  min_q;
	logic [HOUR_W-1:0] hour_q;
	logic [DAY_W-1:0]  day_q;
	logic [YEAR_W-1:0] year_q;

	// nibble to ascii, out of range shows as '?'
	function automatic logic [7:0] digit(input logic [3:0] nib);
		if (nib > 4'd9)
			return 8'h3F;
		else
			return {4'h3, nib};
	endfunction

	assign time_if.ready = ~busy;
	assign char_valid    = busy;

	// ------------------------------------------------------------------------
	// record accept and character sequencing
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			char_idx <= '0;
		end else if (!busy) begin
			if (time_if.valid) begin
				busy     <= 1'b1;
				char_idx <= '0;
			end
		end else if (char_ready) begin
			if (char_idx == 5'(LINE_LAST))
				busy <= 1'b0;
			else
				char_idx <= char_idx + 5'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (time_if.valid && !busy) begin
			sec_q  <= time_if.seconds;
			min_q  <= time_if.minutes;
			hour_q <= time_if.hours;
			day_q  <= time_if.days;
			year_q <= time_if.years;
		end
	end

	// ------------------------------------------------------------------------
	// character select in line order
	// ------------------------------------------------------------------------
	always_comb begin
		case (char_idx)
			5'd0:    char_data = 8'h54;                      // T
			5'd1:    char_data = 8'h49;
			5'd2:    char_data = 8'h4D;
			5'd3:    char_data = 8'h45;
			5'd4:    char_data = 8'h3A;                      // :
			5'd5:    char_data = 8'h32;                      // century "20"
			5'd6:    char_data = 8'h30;
			5'd7:    char_data = digit(year_q[7:4]);
			5'd8:    char_data = digit(year_q[3:0]);
			5'd9:    char_data = 8'h2D;
			5'd10:   char_data = digit({2'b00, day_q[9:8]});  // day hundreds
			5'd11:   char_data = digit(day_q[7:4]);
			5'd12:   char_data = digit(day_q[3:0]);
			5'd13:   char_data = 8'h64;                      // "day"
			5'd14:   char_data = 8'h61;
			5'd15:   char_data = 8'h79;
			5'd16:   char_data = 8'h2D;
			5'd17:   char_data = digit({2'b00, hour_q[5:4]});
			5'd18:   char_data = digit(hour_q[3:0]);
			5'd19:   char_data = 8'h3A;
			5'd20:   char_data = digit({1'b0, min_q[6:4]});
			5'd21:   char_data = digit(min_q[3:0]);
			5'd22:   char_data = 8'h3A;
			5'd23:   char_data = digit({1'b0, sec_q[6:4]});
			5'd24:   char_data = digit(sec_q[3:0]);
			default: char_data = 8'h3F;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/irig_bcd_fields.sv
// irig-b bcd field registers
// maps each symbol index to its bit in the seconds, minutes, hours,
// day of year and year fields and loads it one bit at a time
`timescale 1ns/1ps
`default_nettype none

module irig_bcd_fields (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       fields_clear,
	input  logic       bit_load,
	input  logic [6:0] bit_index,
	input  logic       bit_value,
	irig_time_if.src   time_if
);
	import irig_pkg::*;

	logic [REC_W-1:0]     rec;    // {years, days, hours, minutes, seconds}
	logic [6:0]           offs;
	logic                 hit;
	logic [REC_IDX_W-1:0] pos;

	// ------------------------------------------------------------------------
	// symbol index to record bit, each group is a constant offset
	// ------------------------------------------------------------------------
	always_comb begin
		hit  = 1'b1;
		offs = 7'd0;
		case (bit_index) inside
			[7'd1:7'd4]:   offs = 7'd1;     // seconds units
			[7'd6:7'd8]:   offs = 7'd2;     // seconds tens
			[7'd10:7'd13]: offs = 7'd3;
			[7'd15:7'd17]: offs = 7'd4;     // minutes tens
			[7'd20:7'd23]: offs = 7'd6;
			[7'd25:7'd26]: offs = 7'd7;     // hours tens
			[7'd30:7'd33]: offs = 7'd10;    // day units
			[7'd35:7'd38]: offs = 7'd11;
			[7'd40:7'd41]: offs = 7'd12;    // day hundreds
			[7'd50:7'd53]: offs = 7'd20;    // year units
			[7'd55:7'd58]: offs = 7'd21;
			default:       hit  = 1'b0;     // unused and marker positions
		endcase
	end

	assign pos = REC_IDX_W'(bit_index - offs);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rec <= '0;
		else if (fields_clear)
			rec <= '0;
		else if (bit_load && hit)
			rec[pos] <= bit_value;
	end

	assign {time_if.years, time_if.days, time_if.hours,
		time_if.minutes, time_if.seconds} = rec;

endmodule

`default_nettype wire

// File: hw/irig_decoder_top.sv
// irig-b time code decoder top level
// pulse timer, frame fsm, bcd fields and ascii formatter in a chain
`timescale 1ns/1ps
`default_nettype none

module irig_decoder_top (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       bcode_in,
	output logic [7:0] char_data,
	output logic       char_valid,
	input  logic       char_ready
);
	import irig_pkg::*;

	logic               width_strobe;
	logic [WIDTH_W-1:0] width;
	logic               bit_load;
	logic [6:0]         bit_index;
	logic               bit_value;
	logic               fields_clear;

	irig_time_if time_if ();

	irig_pulse_timer irig_pulse_timer_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.bcode_in     (bcode_in),
		.width_strobe (width_strobe),
		.width        (width)
	);

	irig_frame_fsm irig_frame_fsm_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.width_strobe (width_strobe),
		.width        (width),
		.bit_load     (bit_load),
		.bit_index    (bit_index),
		.bit_value    (bit_value),
		.fields_clear (fields_clear),
		.time_if      (time_if)
	);

	irig_bcd_fields irig_bcd_fields_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.fields_clear (fields_clear),
		.bit_load     (bit_load),
		.bit_index    (bit_index),
		.bit_value    (bit_value),
		.time_if      (time_if)
	);

	irig_ascii_formatter irig_ascii_formatter_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.time_if    (time_if),
		.char_data  (char_data),
		.char_valid (char_valid),
		.char_ready (char_ready)
	);

endmodule

`default_nettype wire

// File: hw/irig_frame_fsm.sv
// irig-b frame state machine
// classifies pulse widths into symbols, finds the reference marker,
// checks the position markers and hands data bits to the field registers
`timescale 1ns/1ps
`default_nettype none

module irig_frame_fsm (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         width_strobe,
	input  logic [irig_pkg::WIDTH_W-1:0] width,
	output logic                         bit_load,
	output logic [6:0]                   bit_index,
	output logic                         bit_value,
	output logic                         fields_clear,
	irig_time_if.ctrl                    time_if
);
	import irig_pkg::*;

	frame_state_t state;
	sym_t         sym;
	logic [6:0]   idx_next;
	logic         marker_slot;   // next index must be a marker

	function automatic logic near(input logic [WIDTH_W-1:0] w, input int nom);
		logic [WIDTH_W-1:0] lo;
		logic [WIDTH_W-1:0] hi;
		lo = WIDTH_W'(nom - W_TOL);
		hi = WIDTH_W'(nom + W_TOL);
		return (w >= lo) && (w <= hi);
	endfunction

	// ------------------------------------------------------------------------
	// symbol classification
	// ------------------------------------------------------------------------
	always_comb begin
		if (near(width, W_ZERO))
			sym = SYM_ZERO;
		else if (near(width, W_ONE))
			sym = SYM_ONE;
		else if (near(width, W_MARK))
			sym = SYM_MARK;
		else
			sym = SYM_BAD;
	end

	assign idx_next = bit_index + 7'd1;

	// P1 to P6
	always_comb begin
		case (idx_next)
			7'd9, 7'd19, 7'd29, 7'd39, 7'd49, 7'(FRAME_LAST): marker_slot = 1'b1;
			default: marker_slot = 1'b0;
		endcase
	end

	// ------------------------------------------------------------------------
	// frame state machine
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= ST_HUNT;
			bit_index    <= '0;
			bit_load     <= 1'b0;
			fields_clear <= 1'b0;
		end else begin
			bit_load     <= 1'b0;
			fields_clear <= 1'b0;
			case (state)
				ST_HUNT: begin
					if (width_strobe && sym == SYM_MARK)
						state <= ST_PREF;
				end
				ST_PREF: begin
					if (width_strobe) begin
						if (sym == SYM_MARK) begin
							state        <= ST_COLLECT;    // reference marker at index 0
							bit_index    <= '0;
							fields_clear <= 1'b1;
						end else begin
							state <= ST_HUNT;
						end
					end
				end
				ST_COLLECT: begin
					if (width_strobe) begin
						bit_index <= idx_next;
						if (marker_slot) begin
							if (sym != SYM_MARK)
								state <= ST_HUNT;
							else if (idx_next == 7'(FRAME_LAST))
								state <= ST_OFFER;
						end else if (sym == SYM_ZERO || sym == SYM_ONE) begin
							bit_load <= 1'b1;
						end else begin
							state <= ST_HUNT;   // bad width or misplaced marker
						end
					end
				end
				ST_OFFER: begin
					if (time_if.ready)
						state <= ST_HUNT;
				end
				default: state <= ST_HUNT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (width_strobe)
			bit_value <= (sym == SYM_ONE);
	end

	assign time_if.valid = (state == ST_OFFER);

endmodule

`default_nettype wire

// File: hw/irig_pkg.sv
// irig-b decoder shared definitions
// symbol timing scaled for simulation, symbol and frame state types,
// bcd field widths of the decoded time record
`default_nettype none

package irig_pkg;

	// ------------------------------------------------------------------------
	// symbol timing in clock cycles
	// ------------------------------------------------------------------------
	localparam int SYM_CYCLES = 100;   // one symbol period
	localparam int W_ZERO     = 20;    // nominal high width of a zero
	localparam int W_ONE      = 50;
	localparam int W_MARK     = 80;    // position marker
	localparam int W_TOL      = 3;     // accepted deviation either way

	localparam int WIDTH_W    = 8;     // pulse width count, saturating
	localparam int FRAME_LAST = 59;    // index of P6

	// ------------------------------------------------------------------------
	// bcd field widths
	// ------------------------------------------------------------------------
	localparam int SEC_W  = 7;
	localparam int MIN_W  = 7;
	localparam int HOUR_W = 6;
	localparam int DAY_W  = 10;
	localparam int YEAR_W = 8;

	// all fields packed as one record, seconds in the low bits
	localparam int REC_W     = SEC_W + MIN_W + HOUR_W + DAY_W + YEAR_W;
	localparam int REC_IDX_W = $clog2(REC_W);

	// last character index of "TIME:20YY-DDDday-HH:MM:SS"
	localparam int LINE_LAST = 24;

	typedef enum logic [1:0] {
		SYM_ZERO,
		SYM_ONE,
		SYM_MARK,
		SYM_BAD
	} sym_t;

	typedef enum logic [1:0] {
		ST_HUNT,       // waiting for a first marker
		ST_PREF,       // one marker seen
		ST_COLLECT,    // inside a frame
		ST_OFFER       // record waiting for the formatter
	} frame_state_t;

endpackage

`default_nettype wire

// File: hw/irig_pulse_timer.sv
// irig-b pulse width timer
// synchronizes the code input, counts the high time of each pulse
// and presents it with a one-cycle strobe after the falling edge
`timescale 1ns/1ps
`default_nettype none

module irig_pulse_timer (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         bcode_in,
	output logic                         width_strobe,
	output logic [irig_pkg::WIDTH_W-1:0] width
);
	import irig_pkg::*;

	logic sync_q1;
	logic sync_q2;
	logic level_q;      // previous synchronized level
	logic rise;
	logic fall;
	logic [WIDTH_W-1:0] count;

	// ------------------------------------------------------------------------
	// two-flop synchronizer and edge detection
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_q1 <= 1'b0;
			sync_q2 <= 1'b0;
			level_q <= 1'b0;
		end else begin
			sync_q1 <= bcode_in;
			sync_q2 <= sync_q1;
			level_q <= sync_q2;
		end
	end

	assign rise = sync_q2 & ~level_q;
	assign fall = level_q & ~sync_q2;

	// high time counter, holds at all ones
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (fall) begin
			count <= '0;
		end else if (rise) begin
			count <= WIDTH_W'(1);    // first high cycle
		end else if (sync_q2 && !(&count)) begin
			count <= count + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			width_strobe <= 1'b0;
		else
			width_strobe <= fall;
	end

	always_ff @(posedge clk) begin
		if (fall)
			width <= count;
	end

endmodule

`default_nettype wire

// File: hw/irig_time_if.sv
// decoded time record from the frame logic to the formatter
// fields come from the bcd registers, valid from the frame fsm
`timescale 1ns/1ps
`default_nettype none

interface irig_time_if;
	import irig_pkg::*;

	logic [SEC_W-1:0]  seconds;
	logic [MIN_W-1:0]  minutes;
	logic [HOUR_W-1:0] hours;
	logic [DAY_W-1:0]  days;
	logic [YEAR_W-1:0] years;
	logic              valid;
	logic              ready;

	// field registers
	modport src (
		output seconds, minutes, hours, days, years
	);

	// frame fsm owns the handshake
	modport ctrl (
		output valid,
		input  ready
	);

	modport snk (
		input  seconds, minutes, hours, days, years, valid,
		output ready
	);

endinterface

`default_nettype wire

// File: vlog.f
hw/irig_pkg.sv
hw/irig_time_if.sv
hw/irig_pulse_timer.sv
hw/irig_frame_fsm.sv
hw/irig_bcd_fields.sv
hw/irig_ascii_formatter.sv
hw/irig_decoder_top.sv
bench/irig_tb.sv
